/* common/matvec_consts.svh */
`ifndef MATVEC_CONSTS_SVH
`define MATVEC_CONSTS_SVH

// vector length, row count and fifo depth
`define MATVEC_N        8
`define MATVEC_ELEM_W   8
`define MATVEC_WORD_W   64
`define MATVEC_ADDR_W   32
`define MATVEC_ACC_W    24
`define MATVEC_B_ADDR   0

// active-low seven-segment codes
`define MATVEC_SEG_OFF  7'b1111111
`define MATVEC_SEG_0    7'b1000000
`define MATVEC_SEG_1    7'b1111001
`define MATVEC_SEG_2    7'b0100100
`define MATVEC_SEG_3    7'b0110000
`define MATVEC_SEG_4    7'b0011001
`define MATVEC_SEG_5    7'b0010010
`define MATVEC_SEG_6    7'b0000010
`define MATVEC_SEG_7    7'b1111000
`define MATVEC_SEG_8    7'b0000000
`define MATVEC_SEG_9    7'b0011000
`define MATVEC_SEG_A    7'b0001000
`define MATVEC_SEG_B    7'b0000011
`define MATVEC_SEG_C    7'b1000110
`define MATVEC_SEG_D    7'b0100001
`define MATVEC_SEG_E    7'b0000110
`define MATVEC_SEG_F    7'b0001110

`endif

/* common/matvec_pkg.sv */
`default_nettype none

`include "matvec_consts.svh"

package matvec_pkg;

  // controller phases, code shown on LEDR
  typedef enum logic [2:0] {
    PH_IDLE    = 3'd0,
    PH_READ    = 3'd1,
    PH_WAIT    = 3'd2,
    PH_UNPACK  = 3'd3,
    PH_COMPUTE = 3'd4,
    PH_DONE    = 3'd5
  } phase_t;

  // memory read request
  typedef struct packed {
    logic                      rd;
    logic [`MATVEC_ADDR_W-1:0] addr;
  } mem_req_t;

  // memory read response, valid for one cycle
  typedef struct packed {
    logic                      valid;
    logic [`MATVEC_WORD_W-1:0] data;
  } mem_rsp_t;

  // bit N selects the B fifo, bits 0..N-1 the row fifos
  typedef struct packed {
    logic [`MATVEC_N:0]        we;
    logic [`MATVEC_ELEM_W-1:0] data;
  } fifo_push_t;

  typedef logic [`MATVEC_N-1:0][`MATVEC_ELEM_W-1:0] lane_bytes_t;
  typedef logic [`MATVEC_N-1:0][`MATVEC_ACC_W-1:0]  lane_acc_t;

endpackage

`default_nettype wire

/* loader/matvec_loader.sv */
`timescale 1ns/100ps
`default_nettype none

`include "matvec_consts.svh"

module matvec_loader (
  input  logic                  CLOCK_50,
  input  logic                  KEY,
  output matvec_pkg::mem_req_t  mem_req,
  input  matvec_pkg::mem_rsp_t  mem_rsp,
  output matvec_pkg::fifo_push_t push,
  input  logic                  all_empty,
  output matvec_pkg::phase_t    phase
);

  import matvec_pkg::*;

  // 0 is the B word, 1..8 are rows A0..A7
  logic [3:0] word_cnt;
  logic [2:0] byte_cnt;

  // element 0 sits in the top byte
  logic [`MATVEC_N-1:0][`MATVEC_ELEM_W-1:0] word_q;

  // ========================================
  // phase FSM and read sequencing
  // ========================================
  always_ff @(posedge CLOCK_50 or negedge KEY) begin
    if (!KEY) begin
      phase    <= PH_IDLE;
      word_cnt <= '0;
      byte_cnt <= '0;
      mem_req  <= '0;
    end else begin
      mem_req.rd <= 1'b0;
      case (phase)
        PH_IDLE: begin
          word_cnt <= '0;
          phase    <= PH_READ;
        end
        PH_READ: begin
          // strobe lands one cycle after entering PH_READ
          mem_req.rd   <= 1'b1;
          mem_req.addr <= `MATVEC_ADDR_W'(`MATVEC_B_ADDR) + `MATVEC_ADDR_W'(word_cnt);
          phase        <= PH_WAIT;
        end
        PH_WAIT: begin
          if (mem_rsp.valid) begin
            byte_cnt <= '0;
            phase    <= PH_UNPACK;
          end
        end
        PH_UNPACK: begin
          byte_cnt <= byte_cnt + 3'd1;
          if (byte_cnt == 3'(`MATVEC_N - 1)) begin
            if (word_cnt == 4'(`MATVEC_N)) begin
              phase <= PH_COMPUTE;
            end else begin
              word_cnt <= word_cnt + 4'd1;
              phase    <= PH_READ;
            end
          end
        end
        PH_COMPUTE: begin
          if (all_empty) begin
            phase <= PH_DONE;
          end
        end
        PH_DONE: begin
          // held until reset
          phase <= PH_DONE;
        end
        default: begin
          phase <= PH_IDLE;
        end
      endcase
    end
  end

  // response word capture
  always_ff @(posedge CLOCK_50) begin
    if (phase == PH_WAIT && mem_rsp.valid) begin
      word_q <= mem_rsp.data;
    end
  end

  // ========================================
  // byte unpack, element 0 first
  // ========================================
  always_comb begin
    push      = '0;
    push.data = word_q[3'(`MATVEC_N - 1) - byte_cnt];
    if (phase == PH_UNPACK) begin
      if (word_cnt == 4'd0) begin
        push.we[`MATVEC_N] = 1'b1;
      end else begin
        // row r lives at word r+1
        push.we[word_cnt - 4'd1] = 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* design/byte_fifo.sv */
`timescale 1ns/100ps
`default_nettype none

`include "matvec_consts.svh"

module byte_fifo #(
  parameter int DEPTH = 8
) (
  input  logic                      CLOCK_50,
  input  logic                      KEY,
  input  logic                      wr,
  input  logic [`MATVEC_ELEM_W-1:0] din,
  input  logic                      rd,
  output logic [`MATVEC_ELEM_W-1:0] dout,
  output logic                      empty,
  output logic                      full
);

  localparam int PTR_W = $clog2(DEPTH);

  logic [`MATVEC_ELEM_W-1:0] mem [DEPTH];
  logic [PTR_W-1:0]          wr_ptr;
  logic [PTR_W-1:0]          rd_ptr;
  logic [PTR_W:0]            count;
  logic                      do_wr;
  logic                      do_rd;

  assign do_wr = wr && !full;
  assign do_rd = rd && !empty;

  // pointers wrap on their own for power-of-two depth
  always_ff @(posedge CLOCK_50 or negedge KEY) begin
    if (!KEY) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) wr_ptr <= wr_ptr + PTR_W'(1);
      if (do_rd) rd_ptr <= rd_ptr + PTR_W'(1);
      case ({do_wr, do_rd})
        2'b10:   count <= count + (PTR_W+1)'(1);
        2'b01:   count <= count - (PTR_W+1)'(1);
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge CLOCK_50) begin
    if (do_wr) mem[wr_ptr] <= din;
  end

  // show-ahead head byte always visible
  assign dout  = mem[rd_ptr];
  assign empty = (count == '0);
  assign full  = (count == DEPTH[PTR_W:0]);

endmodule

`default_nettype wire

/* mac/mac_array.sv */
`timescale 1ns/100ps
`default_nettype none

`include "matvec_consts.svh"

module mac_array (
  input  logic                      CLOCK_50,
  input  logic                      KEY,
  input  matvec_pkg::phase_t        phase,
  input  matvec_pkg::lane_bytes_t   a_head,
  input  logic [`MATVEC_ELEM_W-1:0] b_head,
  input  logic [`MATVEC_N-1:0]      a_empty,
  input  logic                      b_empty,
  output logic                      pop,
  output logic                      all_empty,
  output matvec_pkg::lane_acc_t     acc
);

  import matvec_pkg::*;

  logic in_compute_q;
  logic first_cycle;
  logic lanes_ready;

  // ========================================
  // compute sequencing
  // ========================================
  always_ff @(posedge CLOCK_50 or negedge KEY) begin
    if (!KEY) begin
      in_compute_q <= 1'b0;
    end else begin
      in_compute_q <= (phase == PH_COMPUTE);
    end
  end

  // first compute cycle clears and does not pop
  assign first_cycle = (phase == PH_COMPUTE) && !in_compute_q;

  assign lanes_ready = !b_empty && !(|a_empty);
  assign pop         = (phase == PH_COMPUTE) && !first_cycle && lanes_ready;
  assign all_empty   = b_empty && (&a_empty);

  // ========================================
  // MAC lanes
  // ========================================
  for (genvar g = 0; g < `MATVEC_N; g++) begin : g_lane
    logic [2*`MATVEC_ELEM_W-1:0] prod;
    logic [`MATVEC_ACC_W-1:0]    sum;

    // 8 unsigned terms of 255*255 fit in 24 bits
    assign prod = (2*`MATVEC_ELEM_W)'(a_head[g]) * (2*`MATVEC_ELEM_W)'(b_head);

    always_ff @(posedge CLOCK_50) begin
      if (first_cycle) begin
        sum <= '0;
      end else if (pop) begin
        sum <= sum + `MATVEC_ACC_W'(prod);
      end
    end

    assign acc[g] = sum;
  end

endmodule

`default_nettype wire

/* design/hex_display.sv */
`timescale 1ns/100ps
`default_nettype none

`include "matvec_consts.svh"

module hex_display (
  input  matvec_pkg::phase_t    phase,
  input  logic [9:0]            SW,
  input  matvec_pkg::lane_acc_t acc,
  output logic [6:0]            HEX0,
  output logic [6:0]            HEX1,
  output logic [6:0]            HEX2,
  output logic [6:0]            HEX3,
  output logic [6:0]            HEX4,
  output logic [6:0]            HEX5
);

  import matvec_pkg::*;

  logic [`MATVEC_ACC_W-1:0] sel_acc;
  logic                     show;

  function automatic logic [6:0] seg_decode(input logic [3:0] nib);
    case (nib)
      4'h0:    seg_decode = `MATVEC_SEG_0;
      4'h1:    seg_decode = `MATVEC_SEG_1;
      4'h2:    seg_decode = `MATVEC_SEG_2;
      4'h3:    seg_decode = `MATVEC_SEG_3;
      4'h4:    seg_decode = `MATVEC_SEG_4;
      4'h5:    seg_decode = `MATVEC_SEG_5;
      4'h6:    seg_decode = `MATVEC_SEG_6;
      4'h7:    seg_decode = `MATVEC_SEG_7;
      4'h8:    seg_decode = `MATVEC_SEG_8;
      4'h9:    seg_decode = `MATVEC_SEG_9;
      4'ha:    seg_decode = `MATVEC_SEG_A;
      4'hb:    seg_decode = `MATVEC_SEG_B;
      4'hc:    seg_decode = `MATVEC_SEG_C;
      4'hd:    seg_decode = `MATVEC_SEG_D;
      4'he:    seg_decode = `MATVEC_SEG_E;
      default: seg_decode = `MATVEC_SEG_F;
    endcase
  endfunction

  // row select from SW[3:1]
  assign sel_acc = acc[SW[3:1]];
  assign show    = (phase == PH_DONE) && SW[0];

  // HEX0 is the low nibble
  assign HEX0 = show ? seg_decode(sel_acc[3:0])   : `MATVEC_SEG_OFF;
  assign HEX1 = show ? seg_decode(sel_acc[7:4])   : `MATVEC_SEG_OFF;
  assign HEX2 = show ? seg_decode(sel_acc[11:8])  : `MATVEC_SEG_OFF;
  assign HEX3 = show ? seg_decode(sel_acc[15:12]) : `MATVEC_SEG_OFF;
  assign HEX4 = show ? seg_decode(sel_acc[19:16]) : `MATVEC_SEG_OFF;
  assign HEX5 = show ? seg_decode(sel_acc[23:20]) : `MATVEC_SEG_OFF;

endmodule

`default_nettype wire

/* design/matvec_top.sv */
`timescale 1ns/100ps
`default_nettype none

`include "matvec_consts.svh"

module matvec_top (
  input  logic                 CLOCK_50,
  input  logic                 KEY,
  input  logic [9:0]           SW,
  output logic [9:0]           LEDR,
  output logic [6:0]           HEX0,
  output logic [6:0]           HEX1,
  output logic [6:0]           HEX2,
  output logic [6:0]           HEX3,
  output logic [6:0]           HEX4,
  output logic [6:0]           HEX5,
  output matvec_pkg::mem_req_t mem_req,
  input  matvec_pkg::mem_rsp_t mem_rsp
);

  import matvec_pkg::*;

  phase_t     phase;
  fifo_push_t push;
  logic       pop;
  logic       all_empty;
  lane_acc_t  acc;

  // index N is the B fifo
  logic [`MATVEC_N:0][`MATVEC_ELEM_W-1:0] fifo_dout;
  logic [`MATVEC_N:0]                     fifo_empty;
  logic [`MATVEC_N:0]                     fifo_full;

  matvec_loader matvec_loader_inst (
    .CLOCK_50  (CLOCK_50),
    .KEY       (KEY),
    .mem_req   (mem_req),
    .mem_rsp   (mem_rsp),
    .push      (push),
    .all_empty (all_empty),
    .phase     (phase)
  );

  // ========================================
  // byte fifos, one shared pop
  // ========================================
  for (genvar i = 0; i <= `MATVEC_N; i++) begin : g_fifo
    byte_fifo #(
      .DEPTH (`MATVEC_N)
    ) byte_fifo_inst (
      .CLOCK_50 (CLOCK_50),
      .KEY      (KEY),
      .wr       (push.we[i]),
      .din      (push.data),
      .rd       (pop),
      .dout     (fifo_dout[i]),
      .empty    (fifo_empty[i]),
      .full     (fifo_full[i])
    );
  end

  mac_array mac_array_inst (
    .CLOCK_50  (CLOCK_50),
    .KEY       (KEY),
    .phase     (phase),
    .a_head    (fifo_dout[`MATVEC_N-1:0]),
    .b_head    (fifo_dout[`MATVEC_N]),
    .a_empty   (fifo_empty[`MATVEC_N-1:0]),
    .b_empty   (fifo_empty[`MATVEC_N]),
    .pop       (pop),
    .all_empty (all_empty),
    .acc       (acc)
  );

  hex_display hex_display_inst (
    .phase (phase),
    .SW    (SW),
    .acc   (acc),
    .HEX0  (HEX0),
    .HEX1  (HEX1),
    .HEX2  (HEX2),
    .HEX3  (HEX3),
    .HEX4  (HEX4),
    .HEX5  (HEX5)
  );

  // phase code on the low LEDs
  assign LEDR = {7'd0, phase};

endmodule

`default_nettype wire

/* verif/clock_gen.sv */
`timescale 1ns/100ps
`default_nettype none

module clock_gen (
  output logic clk
);

  // 4 ns period
  initial clk = 1'b0;
  always #2 clk = ~clk;

endmodule

`default_nettype wire

/* verif/matvec_checker.sv */
`timescale 1ns/100ps
`default_nettype none

`include "matvec_consts.svh"

module matvec_checker (
  input  logic                  CLOCK_50,
  input  logic                  KEY,
  input  logic [9:0]            SW,
  input  logic [9:0]            LEDR,
  input  logic [6:0]            HEX0,
  input  logic [6:0]            HEX1,
  input  logic [6:0]            HEX2,
  input  logic [6:0]            HEX3,
  input  logic [6:0]            HEX4,
  input  logic [6:0]            HEX5,
  input  matvec_pkg::mem_req_t  mem_req,
  input  matvec_pkg::lane_acc_t exp_acc,
  input  logic [31:0]           cycle_limit,
  output logic [31:0]           errors,
  output logic [31:0]           hex_checks,
  output logic                  timeout
);

  import matvec_pkg::*;

  localparam logic [41:0] ALL_OFF = {6{`MATVEC_SEG_OFF}};

  logic [41:0] hex_bus;
  logic [31:0] cycles;
  logic [3:0]  next_addr;
  logic        done_seen;

  assign hex_bus = {HEX5, HEX4, HEX3, HEX2, HEX1, HEX0};

  // bit 4 set means not a hex digit code
  function automatic logic [4:0] seg_to_nibble(input logic [6:0] seg);
    case (seg)
      `MATVEC_SEG_0: return 5'h00;
      `MATVEC_SEG_1: return 5'h01;
      `MATVEC_SEG_2: return 5'h02;
      `MATVEC_SEG_3: return 5'h03;
      `MATVEC_SEG_4: return 5'h04;
      `MATVEC_SEG_5: return 5'h05;
      `MATVEC_SEG_6: return 5'h06;
      `MATVEC_SEG_7: return 5'h07;
      `MATVEC_SEG_8: return 5'h08;
      `MATVEC_SEG_9: return 5'h09;
      `MATVEC_SEG_A: return 5'h0a;
      `MATVEC_SEG_B: return 5'h0b;
      `MATVEC_SEG_C: return 5'h0c;
      `MATVEC_SEG_D: return 5'h0d;
      `MATVEC_SEG_E: return 5'h0e;
      `MATVEC_SEG_F: return 5'h0f;
      default:       return 5'h10;
    endcase
  endfunction

  task automatic report_mismatch(input string msg);
    $display("mismatch at %0t: %s", $time, msg);
    errors = errors + 32'd1;
  endtask

  task automatic check_read_address();
    logic [`MATVEC_ADDR_W-1:0] exp_addr;
    exp_addr = `MATVEC_ADDR_W'(`MATVEC_B_ADDR) + `MATVEC_ADDR_W'(next_addr);
    if (next_addr > 4'(`MATVEC_N)) begin
      report_mismatch($sformatf("extra read of address %0d", mem_req.addr));
    end else if (mem_req.addr != exp_addr) begin
      report_mismatch($sformatf("read address %0d, expected %0d", mem_req.addr, exp_addr));
    end
    next_addr = next_addr + 4'd1;
  endtask

  task automatic check_display();
    logic [4:0]               n0, n1, n2, n3, n4, n5;
    logic [`MATVEC_ACC_W-1:0] shown;
    logic [`MATVEC_ACC_W-1:0] exp_val;
    n0 = seg_to_nibble(HEX0);
    n1 = seg_to_nibble(HEX1);
    n2 = seg_to_nibble(HEX2);
    n3 = seg_to_nibble(HEX3);
    n4 = seg_to_nibble(HEX4);
    n5 = seg_to_nibble(HEX5);
    shown   = {n5[3:0], n4[3:0], n3[3:0], n2[3:0], n1[3:0], n0[3:0]};
    exp_val = exp_acc[SW[3:1]];
    if (!SW[0]) begin
      if (hex_bus != ALL_OFF) begin
        report_mismatch($sformatf("display lit with SW[0] low, HEX %h", hex_bus));
      end
    end else if (n0[4] | n1[4] | n2[4] | n3[4] | n4[4] | n5[4]) begin
      report_mismatch($sformatf("row %0d shows a non-hex segment code", SW[3:1]));
    end else if (shown != exp_val) begin
      report_mismatch($sformatf("row %0d shows %h, expected %h", SW[3:1], shown, exp_val));
    end
    hex_checks = hex_checks + 32'd1;
  endtask

  // ========================================
  // sample at the falling edge
  // ========================================
  initial begin : watch
    errors     = '0;
    hex_checks = '0;
    timeout    = 1'b0;
    cycles     = '0;
    next_addr  = '0;
    done_seen  = 1'b0;
    forever begin
      @(negedge CLOCK_50);
      cycles = cycles + 32'd1;
      if (cycles == cycle_limit) begin
        timeout = 1'b1;
      end
      if (!KEY) begin
        if (hex_bus != ALL_OFF || LEDR != 10'd0 || mem_req.rd) begin
          report_mismatch($sformatf("in reset LEDR %0d, read %0b, HEX %h",
                                    LEDR, mem_req.rd, hex_bus));
        end
        next_addr = '0;
        done_seen = 1'b0;
      end else begin
        if (mem_req.rd) begin
          check_read_address();
        end
        if (LEDR == 10'(PH_DONE)) begin
          if (!done_seen && next_addr != 4'(`MATVEC_N + 1)) begin
            report_mismatch($sformatf("%0d reads before done, expected 9", next_addr));
          end
          done_seen = 1'b1;
          check_display();
        end else if (done_seen) begin
          report_mismatch($sformatf("LEDR left the done code, now %0d", LEDR));
        end else if (hex_bus != ALL_OFF) begin
          report_mismatch($sformatf("display lit before done, HEX %h", hex_bus));
        end
      end
    end
  end

endmodule

`default_nettype wire

/* verif/matvec_assert.sv */
`timescale 1ns/100ps
`default_nettype none

`include "matvec_consts.svh"

module matvec_assert (
  input  logic               CLOCK_50,
  input  logic               KEY,
  input  logic [`MATVEC_N:0] push_we,
  input  logic [`MATVEC_N:0] fifo_full,
  input  logic [`MATVEC_N:0] fifo_empty,
  input  logic               rd,
  input  matvec_pkg::phase_t phase
);

  import matvec_pkg::*;

  // a push only lands on a fifo with room
  no_push_when_full: assert property (@(posedge CLOCK_50) disable iff (!KEY)
    (push_we & fifo_full) == '0)
    else $error("byte pushed into a full fifo");

  // nine fifos drain in step so the shared pop never meets an empty one
  fifos_drain_in_step: assert property (@(posedge CLOCK_50) disable iff (!KEY)
    (phase == PH_COMPUTE) |-> (fifo_empty == '0 || fifo_empty == '1))
    else $error("fifos out of step, the shared pop would meet an empty fifo");

  read_strobe_one_cycle: assert property (@(posedge CLOCK_50) disable iff (!KEY)
    rd |=> !rd)
    else $error("read strobe held longer than one cycle");

  done_is_final: assert property (@(posedge CLOCK_50) disable iff (!KEY)
    (phase == PH_DONE) |=> (phase == PH_DONE))
    else $error("phase left PH_DONE without a reset");

endmodule

bind matvec_top matvec_assert matvec_assert_inst (
  .CLOCK_50   (CLOCK_50),
  .KEY        (KEY),
  .push_we    (push.we),
  .fifo_full  (fifo_full),
  .fifo_empty (fifo_empty),
  .rd         (mem_req.rd),
  .phase      (phase)
);

`default_nettype wire

/* verif/matvec_tb.sv */
`timescale 1ns/100ps
`default_nettype none

`include "matvec_consts.svh"

module matvec_tb;

  import matvec_pkg::*;

  localparam int NUM_CASES  = 3;
  // nine memory words then eight expected results
  localparam int CASE_LEN   = 2 * `MATVEC_N + 1;
  localparam int FILE_LEN   = NUM_CASES * CASE_LEN;
  localparam int IDX_W      = $clog2(FILE_LEN);
  // every row plus the off setting, two cycles each
  localparam int MIN_CHECKS = NUM_CASES * (`MATVEC_N + 1) * 2;

  logic        CLOCK_50;
  logic        KEY;
  logic [9:0]  SW;
  logic [9:0]  LEDR;
  logic [6:0]  HEX0;
  logic [6:0]  HEX1;
  logic [6:0]  HEX2;
  logic [6:0]  HEX3;
  logic [6:0]  HEX4;
  logic [6:0]  HEX5;
  mem_req_t    mem_req;
  mem_rsp_t    mem_rsp;

  logic [`MATVEC_WORD_W-1:0] file_words [FILE_LEN];
  logic [`MATVEC_WORD_W-1:0] cur_words [`MATVEC_N + 1];
  lane_acc_t                 exp_acc;
  logic [16:0]               lfsr;
  logic [31:0]               errors;
  logic [31:0]               hex_checks;
  logic [31:0]               cycle_limit;
  logic                      timeout;

  assign cycle_limit = 32'(NUM_CASES * 200);

  clock_gen clock_gen_inst (
    .clk (CLOCK_50)
  );

  matvec_top matvec_top_inst (
    .CLOCK_50 (CLOCK_50),
    .KEY      (KEY),
    .SW       (SW),
    .LEDR     (LEDR),
    .HEX0     (HEX0),
    .HEX1     (HEX1),
    .HEX2     (HEX2),
    .HEX3     (HEX3),
    .HEX4     (HEX4),
    .HEX5     (HEX5),
    .mem_req  (mem_req),
    .mem_rsp  (mem_rsp)
  );

  matvec_checker matvec_checker_inst (
    .CLOCK_50    (CLOCK_50),
    .KEY         (KEY),
    .SW          (SW),
    .LEDR        (LEDR),
    .HEX0        (HEX0),
    .HEX1        (HEX1),
    .HEX2        (HEX2),
    .HEX3        (HEX3),
    .HEX4        (HEX4),
    .HEX5        (HEX5),
    .mem_req     (mem_req),
    .exp_acc     (exp_acc),
    .cycle_limit (cycle_limit),
    .errors      (errors),
    .hex_checks  (hex_checks),
    .timeout     (timeout)
  );

  // taps 17 and 14
  function automatic logic [16:0] lfsr_next(input logic [16:0] s);
    return {s[15:0], s[16] ^ s[13]};
  endfunction

  // words past the image get an address-derived fill
  function automatic logic [`MATVEC_WORD_W-1:0] read_word(input logic [31:0] addr);
    if (addr <= 32'(`MATVEC_N)) begin
      return cur_words[addr[3:0]];
    end
    return {addr, ~addr};
  endfunction

  task automatic next_cycle();
    @(posedge CLOCK_50);
    #1;
  endtask

  task automatic load_case(input int c);
    logic [IDX_W-1:0] idx;
    idx = IDX_W'(c * CASE_LEN);
    for (int w = 0; w <= `MATVEC_N; w++) begin
      cur_words[4'(w)] = file_words[idx];
      idx = idx + IDX_W'(1);
    end
    for (int r = 0; r < `MATVEC_N; r++) begin
      exp_acc[r[2:0]] = file_words[idx][`MATVEC_ACC_W-1:0];
      idx = idx + IDX_W'(1);
    end
  endtask

  task automatic apply_reset();
    next_cycle();
    KEY = 1'b0;
    repeat (3) next_cycle();
    KEY = 1'b1;
  endtask

  task automatic sweep_display();
    for (int r = 0; r < `MATVEC_N; r++) begin
      SW = {6'd0, r[2:0], 1'b1};
      repeat (2) next_cycle();
    end
    SW = '0;
    repeat (2) next_cycle();
  endtask

  // ========================================
  // memory model, one request at a time
  // ========================================
  initial begin : memory_model
    logic [`MATVEC_ADDR_W-1:0] addr;
    logic [1:0]                lat;
    mem_rsp = '0;
    lfsr    = 17'd69559;
    forever begin
      next_cycle();
      mem_rsp.valid = 1'b0;
      if (KEY && mem_req.rd) begin
        addr   = mem_req.addr;
        lfsr   = lfsr_next(lfsr);
        lat[0] = lfsr[0];
        lfsr   = lfsr_next(lfsr);
        lat[1] = lfsr[0];
        // 1 to 4 cycles
        repeat ({1'b0, lat} + 3'd1) next_cycle();
        mem_rsp.data  = read_word(addr);
        mem_rsp.valid = 1'b1;
      end
    end
  end

  // ========================================
  // case sequencing
  // ========================================
  initial begin : stimulus
    logic fail;
    KEY     = 1'b0;
    SW      = '0;
    exp_acc = '0;
    $readmemh("verif/matvec_input.txt", file_words);
    for (int c = 0; c < NUM_CASES; c++) begin
      load_case(c);
      apply_reset();
      while (LEDR != 10'(PH_DONE)) begin
        next_cycle();
      end
      sweep_display();
    end
    fail = (errors != 32'd0);
    if (hex_checks < 32'(MIN_CHECKS)) begin
      $display("only %0d display checks were made, at least %0d needed",
               hex_checks, MIN_CHECKS);
      fail = 1'b1;
    end
    $display("errors %0d, display checks %0d", errors, hex_checks);
    if (fail) begin
      $display("Testbench failed");
    end else begin
      $display("Testbench passed");
    end
    $finish;
  end

  initial begin : watchdog
    wait (timeout);
    $display("timeout: the run did not finish all cases within %0d cycles", cycle_limit);
    $display("errors %0d, display checks %0d", errors, hex_checks);
    $display("Testbench failed");
    $finish;
  end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+common
common/matvec_pkg.sv
loader/matvec_loader.sv
design/byte_fifo.sv
mac/mac_array.sv
design/hex_display.sv
design/matvec_top.sv
verif/clock_gen.sv
verif/matvec_checker.sv
verif/matvec_assert.sv
verif/matvec_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the matvec testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --top-module matvec_tb \
  -f verilog.f --Mdir obj_dir -o matvec_sim
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/matvec_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Testbench failed" "$LOG"; then
  exit 1
fi
if ! grep -q "Testbench passed" "$LOG"; then
  echo "simulation ended without a result line"
  exit 1
fi
exit 0

/* verif/matvec_input.txt */
// per case: nine 64-bit words (B, then rows A0 to A7), element 0 in the top byte,
// then the eight expected 24-bit dot products of rows 0 to 7
// case 0, position checks against B = 1..8
0102030405060708 0100000000000000 0000000000000001
0101010101010101 0807060504030201 ffffffffffffffff
1000000000000000 0000000000000010 0200000000000003
000001 000008 000024 000078 0023dc 000010 000080 00001a
// case 1, B all ones, largest sums
ffffffffffffffff ffffffffffffffff 0000000000000000
0101010101010101 0102030405060708 8000000000000000
0000000000000080 1122334455667788 fe00000000000001
07f008 000000 0007f8 0023dc 007f80 007f80 02619c 00fe01
// case 2, B with only the end elements set
8000000000000001 0102030405060708 0807060504030201
ffffffffffffffff 0000000000000000 1200000000000034
ab00000000000000 00ffffffffffff00 02000000000000ff
000088 000401 00807f 000000 000934 005580 000000 0001ff
